// ==== source/sort_params.svh ====
`ifndef SORT_PARAMS_SVH
`define SORT_PARAMS_SVH

// entries per item
`define SORT_N 8

// character code width
`define SORT_CHAR_W 4

// weight width, the primary sort key
`define SORT_WEIGHT_W 5

`endif

// ==== source/sort_pkg.sv ====
`include "sort_params.svh"

package sort_pkg;

    // 4-bit character code
    typedef logic [`SORT_CHAR_W-1:0] char_t;

    // 5-bit weight
    typedef logic [`SORT_WEIGHT_W-1:0] weight_t;

    // weight in the upper bits, so the raw value already orders by weight first
    typedef struct packed {
        weight_t weight;
        char_t   character;
    } entry_t;

    // index 0 is the leftmost element, matching the bus packing at the top
    typedef entry_t [0:`SORT_N-1] entry_vec_t;

endpackage

// ==== source/sort_lane_if.sv ====
`timescale 1ns/1ps

interface sort_lane_if;
    import sort_pkg::*;

    // one item per cycle while valid is high
    logic       valid;
    entry_vec_t entries;

    modport src (
        output valid,
        output entries
    );

    modport dst (
        input valid,
        input entries
    );

endinterface

// ==== source/sort_cas.sv ====
`timescale 1ns/1ps

module sort_cas (
    input  sort_pkg::entry_t a,
    input  sort_pkg::entry_t b,
    output sort_pkg::entry_t hi,
    output sort_pkg::entry_t lo
);
    import sort_pkg::*;

    logic    a_first;
    weight_t wa;
    weight_t wb;
    char_t   ca;
    char_t   cb;

    assign wa = a.weight;
    assign wb = b.weight;
    assign ca = a.character;
    assign cb = b.character;

    // heavier first, then higher code; a full tie keeps a on top
    assign a_first = (wa > wb) || ((wa == wb) && (ca >= cb));

    assign hi = a_first ? a : b;
    assign lo = a_first ? b : a;

endmodule

// ==== source/sort_capture.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_capture (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  logic [`SORT_N*`SORT_CHAR_W-1:0]     in_character,
    input  logic [`SORT_N*`SORT_WEIGHT_W-1:0]   in_weight,
    sort_lane_if.src                            lane
);
    import sort_pkg::*;

    entry_vec_t unpacked;

    // entry 0 comes from the top field of each bus
    always_comb begin
        for (int i = 0; i < `SORT_N; i++) begin
            unpacked[i].character =
                in_character[(`SORT_N-1-i)*`SORT_CHAR_W +: `SORT_CHAR_W];
            unpacked[i].weight =
                in_weight[(`SORT_N-1-i)*`SORT_WEIGHT_W +: `SORT_WEIGHT_W];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.valid   <= 1'b0;
            lane.entries <= '0;
        end else begin
            lane.valid   <= in_valid;
            // loads every cycle, qualified downstream by valid
            lane.entries <= unpacked;
        end
    end

endmodule

// ==== source/sort_half_sorter.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_half_sorter (
    input  logic     clk,
    input  logic     arst_n,
    sort_lane_if.dst up,
    sort_lane_if.src down
);
    import sort_pkg::*;

    entry_t l1     [`SORT_N];
    entry_t l2     [`SORT_N];
    entry_t sorted [`SORT_N];

    // ==================================================
    // four-entry odd-even merge sort, one per half
    // ==================================================
    for (genvar h = 0; h < 2; h++) begin : g_half
        localparam int base = 4 * h;

        // layer 1, adjacent pairs
        sort_cas u_l1_a (
            .a  (up.entries[base+0]),
            .b  (up.entries[base+1]),
            .hi (l1[base+0]),
            .lo (l1[base+1])
        );
        sort_cas u_l1_b (
            .a  (up.entries[base+2]),
            .b  (up.entries[base+3]),
            .hi (l1[base+2]),
            .lo (l1[base+3])
        );

        // layer 2, merge the sorted pairs
        sort_cas u_l2_a (
            .a  (l1[base+0]),
            .b  (l1[base+2]),
            .hi (l2[base+0]),
            .lo (l2[base+2])
        );
        sort_cas u_l2_b (
            .a  (l1[base+1]),
            .b  (l1[base+3]),
            .hi (l2[base+1]),
            .lo (l2[base+3])
        );

        // layer 3, only the middle pair can still be out of order
        sort_cas u_l3 (
            .a  (l2[base+1]),
            .b  (l2[base+2]),
            .hi (sorted[base+1]),
            .lo (sorted[base+2])
        );

        assign sorted[base+0] = l2[base+0];
        assign sorted[base+3] = l2[base+3];
    end

    // ==================================================
    // stage register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down.valid   <= 1'b0;
            down.entries <= '0;
        end else begin
            down.valid <= up.valid;
            for (int i = 0; i < `SORT_N; i++) begin
                down.entries[i] <= sorted[i];
            end
        end
    end

endmodule

// ==== source/sort_merger.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_merger (
    input  logic                            clk,
    input  logic                            arst_n,
    sort_lane_if.dst                        up,
    output logic                            out_valid,
    output logic [`SORT_N*`SORT_CHAR_W-1:0] out_character
);
    import sort_pkg::*;

    entry_t m1     [`SORT_N];
    entry_t m2     [`SORT_N];
    entry_t ranked [`SORT_N];

    logic [`SORT_N*`SORT_CHAR_W-1:0] packed_codes;

    // ==================================================
    // odd-even merge of two sorted halves
    // ==================================================

    // layer 1, entry i against entry i+4
    for (genvar i = 0; i < 4; i++) begin : g_l1
        sort_cas u_cas (
            .a  (up.entries[i]),
            .b  (up.entries[i+4]),
            .hi (m1[i]),
            .lo (m1[i+4])
        );
    end

    // layer 2
    sort_cas u_l2_a (
        .a  (m1[2]),
        .b  (m1[4]),
        .hi (m2[2]),
        .lo (m2[4])
    );
    sort_cas u_l2_b (
        .a  (m1[3]),
        .b  (m1[5]),
        .hi (m2[3]),
        .lo (m2[5])
    );

    assign m2[0] = m1[0];
    assign m2[1] = m1[1];
    assign m2[6] = m1[6];
    assign m2[7] = m1[7];

    // layer 3, neighbours 1-2, 3-4, 5-6
    for (genvar j = 0; j < 3; j++) begin : g_l3
        sort_cas u_cas (
            .a  (m2[2*j+1]),
            .b  (m2[2*j+2]),
            .hi (ranked[2*j+1]),
            .lo (ranked[2*j+2])
        );
    end

    assign ranked[0] = m2[0];
    assign ranked[7] = m2[7];

    // rank 0 lands in the top nibble, weights dropped
    always_comb begin
        packed_codes = '0;
        for (int r = 0; r < `SORT_N; r++) begin
            packed_codes[(`SORT_N-1-r)*`SORT_CHAR_W +: `SORT_CHAR_W] = ranked[r].character;
        end
    end

    // ==================================================
    // output register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid     <= 1'b0;
            out_character <= '0;
        end else begin
            out_valid     <= up.valid;
            out_character <= packed_codes;
        end
    end

endmodule

// ==== source/sort_top.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [`SORT_N*`SORT_CHAR_W-1:0]   in_character,
    input  logic [`SORT_N*`SORT_WEIGHT_W-1:0] in_weight,
    output logic                              out_valid,
    output logic [`SORT_N*`SORT_CHAR_W-1:0]   out_character
);

    // ==================================================
    // stage lanes
    // ==================================================
    sort_lane_if cap_lane ();
    sort_lane_if half_lane ();

    // ==================================================
    // pipeline, 3 cycles from in_valid to out_valid
    // ==================================================

    // capture and unpack
    sort_capture u_capture (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_character (in_character),
        .in_weight    (in_weight),
        .lane         (cap_lane.src)
    );

    // sort each group of four
    sort_half_sorter u_half_sorter (
        .clk    (clk),
        .arst_n (arst_n),
        .up     (cap_lane.dst),
        .down   (half_lane.src)
    );

    // merge halves and pack codes
    sort_merger u_merger (
        .clk           (clk),
        .arst_n        (arst_n),
        .up            (half_lane.dst),
        .out_valid     (out_valid),
        .out_character (out_character)
    );

endmodule

// ==== test/tb_sort_top.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module tb_sort_top;

    // counts the sampling edge, then the half-sort and merge registers
    localparam int LATENCY = 3;

    logic                              clk;
    logic                              arst_n;
    logic                              in_valid;
    logic [`SORT_N*`SORT_CHAR_W-1:0]   in_character;
    logic [`SORT_N*`SORT_WEIGHT_W-1:0] in_weight;
    logic                              out_valid;
    logic [`SORT_N*`SORT_CHAR_W-1:0]   out_character;

    logic [31:0] rng = 32'h9c83;
    int          edge_cnt = 0;
    int          sent_cnt = 0;
    int          driven_cnt = 0;
    int          recv_cnt = 0;
    string       test_name = "reset_quiet";

    logic [`SORT_N*`SORT_CHAR_W-1:0] exp_q [$];
    string                           name_q [$];
    int                              due_q [$];

    sort_top dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_character  (in_character),
        .in_weight     (in_weight),
        .out_valid     (out_valid),
        .out_character (out_character)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // descending weight, then descending code, rank 0 in the top nibble
    function automatic logic [`SORT_N*`SORT_CHAR_W-1:0] expected_codes(
        input logic [`SORT_N*`SORT_CHAR_W-1:0]   chars,
        input logic [`SORT_N*`SORT_WEIGHT_W-1:0] weights
    );
        logic [`SORT_CHAR_W-1:0]         c [`SORT_N];
        logic [`SORT_WEIGHT_W-1:0]       w [`SORT_N];
        logic [`SORT_CHAR_W-1:0]         tc;
        logic [`SORT_WEIGHT_W-1:0]       tw;
        logic [`SORT_N*`SORT_CHAR_W-1:0] res;
        for (int i = 0; i < `SORT_N; i++) begin
            c[i] = chars[(`SORT_N-1-i)*`SORT_CHAR_W +: `SORT_CHAR_W];
            w[i] = weights[(`SORT_N-1-i)*`SORT_WEIGHT_W +: `SORT_WEIGHT_W];
        end
        for (int i = 0; i < `SORT_N - 1; i++) begin
            for (int j = i + 1; j < `SORT_N; j++) begin
                if (w[j] > w[i] || (w[j] == w[i] && c[j] > c[i])) begin
                    tc = c[i];
                    tw = w[i];
                    c[i] = c[j];
                    w[i] = w[j];
                    c[j] = tc;
                    w[j] = tw;
                end
            end
        end
        res = '0;
        for (int r = 0; r < `SORT_N; r++) begin
            res[(`SORT_N-1-r)*`SORT_CHAR_W +: `SORT_CHAR_W] = c[r];
        end
        return res;
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic send_item(input string name,
                             input logic [`SORT_N*`SORT_CHAR_W-1:0]   chars,
                             input logic [`SORT_N*`SORT_WEIGHT_W-1:0] weights);
        @(posedge clk);
        test_name    = name;
        in_valid     <= 1'b1;
        in_character <= chars;
        in_weight    <= weights;
        driven_cnt++;
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), limit);
            stop_on_error();
        end
    endtask

    task automatic run_directed(input string name,
                                input logic [`SORT_N*`SORT_CHAR_W-1:0]   chars,
                                input logic [`SORT_N*`SORT_WEIGHT_W-1:0] weights);
        send_item(name, chars, weights);
        go_idle();
        wait_drain(20);
    endtask

    // small weight range on odd items for plenty of ties
    task automatic send_random(input int idx);
        logic [`SORT_N*`SORT_CHAR_W-1:0]   chars;
        logic [`SORT_N*`SORT_WEIGHT_W-1:0] weights;
        for (int i = 0; i < `SORT_N; i++) begin
            rng = xorshift32(rng);
            chars[i*`SORT_CHAR_W +: `SORT_CHAR_W] = rng[3:0];
            if (idx % 2 == 1) begin
                weights[i*`SORT_WEIGHT_W +: `SORT_WEIGHT_W] = {3'b000, rng[5:4]};
            end else begin
                weights[i*`SORT_WEIGHT_W +: `SORT_WEIGHT_W] = rng[8:4];
            end
        end
        send_item($sformatf("stream_%0d", idx), chars, weights);
    endtask

    // ==================================================
    // monitor and scoreboard, sampled at the falling edge
    // ==================================================
    always @(negedge clk) begin : scoreboard
        logic [`SORT_N*`SORT_CHAR_W-1:0] exp_val;
        string                           exp_name;
        int                              exp_due;
        if (sent_cnt == 0) begin
            check("reset_quiet valid", 32'd0, 32'(out_valid));
            check("reset_quiet data", 32'd0, out_character);
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output: out_valid high with no result pending");
                stop_on_error();
            end else begin
                exp_val  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_due  = due_q.pop_front();
                check(exp_name, exp_val, out_character);
                check({exp_name, " latency"}, exp_due, edge_cnt);
                recv_cnt++;
            end
        end else if (due_q.size() != 0 && due_q[0] <= edge_cnt) begin
            $display("out_valid stayed low when the result for %s was due", name_q[0]);
            stop_on_error();
        end
        // item in flight, sampled at the next rising edge
        if (arst_n && in_valid) begin
            exp_q.push_back(expected_codes(in_character, in_weight));
            name_q.push_back(test_name);
            due_q.push_back(edge_cnt + LATENCY);
            sent_cnt++;
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_character = '0;
        in_weight    = '0;

        // hand-worked case for the reference itself
        check("reference all_equal", 32'hfca7_5310,
              expected_codes(32'h3a1f_0c75, {8{5'd9}}));

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // distinct weights
        run_directed("ascending", 32'h0123_4567,
                     {5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7});
        run_directed("descending", 32'h89ab_cdef,
                     {5'd31, 5'd27, 5'd22, 5'd18, 5'd13, 5'd9, 5'd4, 5'd1});
        run_directed("mixed", 32'h5e2b_917c,
                     {5'd12, 5'd30, 5'd3, 5'd25, 5'd17, 5'd8, 5'd21, 5'd0});

        // ties on weight
        run_directed("all_equal", 32'h3a1f_0c75, {8{5'd9}});
        run_directed("pair_ties", 32'h1234_5678,
                     {5'd6, 5'd6, 5'd20, 5'd20, 5'd2, 5'd2, 5'd11, 5'd11});
        run_directed("duplicates", 32'h5555_5555, {8{5'd12}});
        run_directed("mixed_dups", 32'h7a7a_0303,
                     {5'd4, 5'd4, 5'd4, 5'd4, 5'd19, 5'd19, 5'd1, 5'd1});

        // streaming with random gaps
        for (int n = 0; n < 300; n++) begin
            send_random(n);
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00) begin
                go_idle();
            end
        end
        go_idle();
        wait_drain(50);

        // quiet window, any late extra result trips the monitor
        repeat (LATENCY + 2) @(posedge clk);

        check("output count", driven_cnt, recv_cnt);

        $display("No errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/sort_pkg.sv
source/sort_lane_if.sv
source/sort_cas.sv
source/sort_capture.sv
source/sort_half_sorter.sv
source/sort_merger.sv
source/sort_top.sv
test/tb_sort_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sorter testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv \
    -f filelist.f \
    --top-module tb_sort_top \
    --Mdir obj_dir \
    -o tb_sort_top_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/tb_sort_top_sim 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
